// ==== src/mem_map_pkg.sv ====
// memory map of the bus fabric
// address ranges, bus widths and the LED register location
`default_nettype none

package mem_map_pkg;

  // bus widths
  localparam int unsigned ADDR_W = 32;
  localparam int unsigned DATA_W = 32;
  // one enable per byte lane
  localparam int unsigned BE_W = DATA_W / 8;

  // flash below this address, on-chip RAM at and above
  localparam logic [ADDR_W-1:0] RAM_OFFSET = 32'h0000_D000;

  // default RAM size only
  // the top level parameter sets the depth in use
  localparam int unsigned RAM_SIZE_BYTES = 8 * 1024;

  // LED register shares the first RAM word
  localparam logic [ADDR_W-1:0] LED_ADDR = RAM_OFFSET;

endpackage

`default_nettype wire

// ==== src/bus_pkg.sv ====
// bus types of the fabric
// word types, flash arbiter states and access kinds
`default_nettype none

package bus_pkg;

  // byte address, data word and byte enables
  typedef logic [mem_map_pkg::ADDR_W-1:0] addr_t;
  typedef logic [mem_map_pkg::DATA_W-1:0] word_t;
  typedef logic [mem_map_pkg::BE_W-1:0]   be_t;

  // flash arbiter states
  typedef enum logic [1:0] {
    FLASH_IDLE       = 2'b00,
    FLASH_INSTR_READ = 2'b01,
    FLASH_DATA_READ  = 2'b10,
    FLASH_DATA_WRITE = 2'b11
  } flash_state_e;

  // kind of a data-side access
  typedef enum logic {
    ACC_READ  = 1'b0,
    ACC_WRITE = 1'b1
  } access_e;

endpackage

`default_nettype wire

// ==== src/data_bus_if.sv ====
// data-side request/response channel
// req/gnt handshake with one rvalid pulse per grant
`default_nettype none

interface data_bus_if;
  import bus_pkg::*;

  // request, held with payload until gnt
  logic    req;
  access_e kind;
  addr_t   addr;
  be_t     be;
  word_t   wdata;

  // grant and response
  logic    gnt;
  logic    rvalid;
  word_t   rdata;

  // router side
  modport requester (
    output req, kind, addr, be, wdata,
    input  gnt, rvalid, rdata
  );

  // flash arbiter and RAM side
  modport responder (
    input  req, kind, addr, be, wdata,
    output gnt, rvalid, rdata
  );

endinterface

`default_nettype wire

// ==== src/flash_arbiter.sv ====
// flash arbiter
// serializes instruction and data accesses onto the external flash,
// instructions first, with byte order swapped both ways
`default_nettype none

module flash_arbiter (
  input  logic           IO_CLK,
  input  logic           IO_RST_N,
  // instruction port, reads only
  input  logic           instr_req_i,
  input  bus_pkg::addr_t instr_addr_i,
  output logic           instr_gnt_o,
  output logic           instr_rvalid_o,
  output bus_pkg::word_t instr_rdata_o,
  // data accesses below the RAM offset
  data_bus_if.responder  dbus,
  // external flash
  output logic           flash_read_o,
  output logic           flash_write_o,
  output bus_pkg::addr_t flash_addr_o,
  output bus_pkg::be_t   flash_be_o,
  output bus_pkg::word_t flash_wdata_o,
  input  bus_pkg::word_t flash_rdata_i,
  input  logic           flash_rvalid_i,
  input  logic           flash_wait_i
);
  import mem_map_pkg::*;
  import bus_pkg::*;

  flash_state_e state_q;
  logic         take_instr;
  logic         take_data;
  word_t        rdata_swapped;

  // reverse the byte lanes of a word
  function automatic word_t byte_swap(input word_t w);
    word_t s;
    for (int i = 0; i < BE_W; i++) begin
      s[i*8 +: 8] = w[(BE_W-1-i)*8 +: 8];
    end
    return s;
  endfunction

  // only taken from idle, instruction wins a tie
  assign take_instr = (state_q == FLASH_IDLE) && instr_req_i;
  assign take_data  = (state_q == FLASH_IDLE) && !instr_req_i && dbus.req;

  assign rdata_swapped = byte_swap(flash_rdata_i);

  always_ff @(posedge IO_CLK or negedge IO_RST_N) begin
    if (!IO_RST_N) begin
      state_q        <= FLASH_IDLE;
      instr_gnt_o    <= 1'b0;
      instr_rvalid_o <= 1'b0;
      dbus.gnt       <= 1'b0;
      dbus.rvalid    <= 1'b0;
      flash_read_o   <= 1'b0;
      flash_write_o  <= 1'b0;
    end else begin
      // grants and responses are single-cycle pulses
      instr_gnt_o    <= 1'b0;
      instr_rvalid_o <= 1'b0;
      dbus.gnt       <= 1'b0;
      dbus.rvalid    <= 1'b0;
      case (state_q)
        FLASH_IDLE: begin
          if (take_instr) begin
            state_q      <= FLASH_INSTR_READ;
            instr_gnt_o  <= 1'b1;
            flash_read_o <= 1'b1;
          end else if (take_data) begin
            state_q       <= (dbus.kind == ACC_WRITE) ? FLASH_DATA_WRITE : FLASH_DATA_READ;
            dbus.gnt      <= 1'b1;
            flash_read_o  <= (dbus.kind == ACC_READ);
            flash_write_o <= (dbus.kind == ACC_WRITE);
          end
        end
        FLASH_INSTR_READ: begin
          // strobe held until flash accepts
          if (flash_read_o && !flash_wait_i) begin
            flash_read_o <= 1'b0;
          end
          if (flash_rvalid_i) begin
            instr_rvalid_o <= 1'b1;
            state_q        <= FLASH_IDLE;
          end
        end
        FLASH_DATA_READ: begin
          if (flash_read_o && !flash_wait_i) begin
            flash_read_o <= 1'b0;
          end
          if (flash_rvalid_i) begin
            dbus.rvalid <= 1'b1;
            state_q     <= FLASH_IDLE;
          end
        end
        FLASH_DATA_WRITE: begin
          // a write completes at acceptance
          if (!flash_wait_i) begin
            flash_write_o <= 1'b0;
            dbus.rvalid   <= 1'b1;
            state_q       <= FLASH_IDLE;
          end
        end
        default: begin
          state_q <= FLASH_IDLE;
        end
      endcase
    end
  end

  // flash payload, loaded with the strobe
  always_ff @(posedge IO_CLK) begin
    if (take_instr) begin
      flash_addr_o <= instr_addr_i >> 2;
      flash_be_o   <= '1;
    end else if (take_data) begin
      flash_addr_o  <= dbus.addr >> 2;
      flash_be_o    <= dbus.be;
      flash_wdata_o <= byte_swap(dbus.wdata);
    end
    // read data back to the port that asked
    if (flash_rvalid_i && state_q == FLASH_INSTR_READ) begin
      instr_rdata_o <= rdata_swapped;
    end
    if (flash_rvalid_i && state_q == FLASH_DATA_READ) begin
      dbus.rdata <= rdata_swapped;
    end
  end

endmodule

`default_nettype wire

// ==== src/ram_and_led_port.sv ====
// on-chip RAM port with one-cycle read
// also holds the 4-bit LED register at the first RAM word
`default_nettype none

module ram_and_led_port #(
  parameter int unsigned ram_words = mem_map_pkg::RAM_SIZE_BYTES / 4
) (
  input  logic          IO_CLK,
  input  logic          IO_RST_N,
  data_bus_if.responder dbus,
  output logic [3:0]    leds_o
);
  import mem_map_pkg::*;
  import bus_pkg::*;

  localparam int unsigned idx_w = $clog2(ram_words);

  word_t            mem_q [ram_words];
  addr_t            offset;
  logic [idx_w-1:0] word_idx;
  logic             wr_en;
  logic             led_wr;
  logic [3:0]       led_nibble;

  // never stalls
  assign dbus.gnt = dbus.req;

  // word index relative to the RAM base, wraps at ram_words
  assign offset   = dbus.addr - RAM_OFFSET;
  assign word_idx = offset[idx_w+1:2];

  assign wr_en  = dbus.req && (dbus.kind == ACC_WRITE);
  assign led_wr = wr_en && (dbus.addr == LED_ADDR);

  // low nibble of the highest enabled byte
  always_comb begin
    led_nibble = leds_o;
    for (int i = 0; i < BE_W; i++) begin
      if (dbus.be[i]) begin
        led_nibble = dbus.wdata[i*8 +: 4];
      end
    end
  end

  // old word is read before the write lands
  always_ff @(posedge IO_CLK) begin
    if (dbus.req) begin
      dbus.rdata <= mem_q[word_idx];
    end
    if (wr_en) begin
      for (int i = 0; i < BE_W; i++) begin
        if (dbus.be[i]) begin
          mem_q[word_idx][i*8 +: 8] <= dbus.wdata[i*8 +: 8];
        end
      end
    end
  end

  always_ff @(posedge IO_CLK or negedge IO_RST_N) begin
    if (!IO_RST_N) begin
      dbus.rvalid <= 1'b0;
      leds_o      <= 4'b0;
    end else begin
      // response one cycle after grant
      dbus.rvalid <= dbus.req;
      if (led_wr) begin
        leds_o <= led_nibble;
      end
    end
  end

endmodule

`default_nettype wire

// ==== src/data_router.sv ====
// data port router
// splits core data requests between flash and RAM by address and
// merges the two responses back onto the core port
`default_nettype none

module data_router (
  input  logic             IO_CLK,
  input  logic             IO_RST_N,
  // core data port
  input  logic             data_req_i,
  input  logic             data_we_i,
  input  bus_pkg::be_t     data_be_i,
  input  bus_pkg::addr_t   data_addr_i,
  input  bus_pkg::word_t   data_wdata_i,
  output logic             data_gnt_o,
  output logic             data_rvalid_o,
  output bus_pkg::word_t   data_rdata_o,
  // the two sides
  data_bus_if.requester    flash_dbus,
  data_bus_if.requester    ram_dbus
);
  import mem_map_pkg::*;
  import bus_pkg::*;

  logic    is_ram;
  logic    busy_q;
  access_e kind;

  assign is_ram = (data_addr_i >= RAM_OFFSET);
  assign kind   = data_we_i ? ACC_WRITE : ACC_READ;

  // new requests wait while a flash data access is in flight
  assign flash_dbus.req = data_req_i && !is_ram && !busy_q;
  assign ram_dbus.req   = data_req_i && is_ram && !busy_q;

  // same payload to both, only one sees req
  assign flash_dbus.kind  = kind;
  assign flash_dbus.addr  = data_addr_i;
  assign flash_dbus.be    = data_be_i;
  assign flash_dbus.wdata = data_wdata_i;
  assign ram_dbus.kind    = kind;
  assign ram_dbus.addr    = data_addr_i;
  assign ram_dbus.be      = data_be_i;
  assign ram_dbus.wdata   = data_wdata_i;

  // set on flash grant, cleared by its rvalid
  always_ff @(posedge IO_CLK or negedge IO_RST_N) begin
    if (!IO_RST_N) begin
      busy_q <= 1'b0;
    end else if (flash_dbus.gnt) begin
      busy_q <= 1'b1;
    end else if (flash_dbus.rvalid) begin
      busy_q <= 1'b0;
    end
  end

  // merge back, sides never pulse together
  assign data_gnt_o    = !busy_q && (flash_dbus.gnt || ram_dbus.gnt);
  assign data_rvalid_o = flash_dbus.rvalid || ram_dbus.rvalid;
  assign data_rdata_o  = ram_dbus.rvalid ? ram_dbus.rdata : flash_dbus.rdata;

endmodule

`default_nettype wire

// ==== src/soc_bus_fabric.sv ====
// memory fabric between the core's instruction and data ports,
// the external flash and the on-chip RAM with LED register
`default_nettype none

module soc_bus_fabric #(
  parameter int unsigned ram_words = mem_map_pkg::RAM_SIZE_BYTES / 4
) (
  input  logic           IO_CLK,
  input  logic           IO_RST_N,
  // instruction port
  input  logic           instr_req_i,
  input  bus_pkg::addr_t instr_addr_i,
  output logic           instr_gnt_o,
  output logic           instr_rvalid_o,
  output bus_pkg::word_t instr_rdata_o,
  // data port
  input  logic           data_req_i,
  input  logic           data_we_i,
  input  bus_pkg::be_t   data_be_i,
  input  bus_pkg::addr_t data_addr_i,
  input  bus_pkg::word_t data_wdata_i,
  output logic           data_gnt_o,
  output logic           data_rvalid_o,
  output bus_pkg::word_t data_rdata_o,
  // external flash, word addressed
  output logic           flash_read_o,
  output logic           flash_write_o,
  output bus_pkg::addr_t flash_addr_o,
  output bus_pkg::be_t   flash_be_o,
  output bus_pkg::word_t flash_wdata_o,
  input  bus_pkg::word_t flash_rdata_i,
  input  logic           flash_rvalid_i,
  input  logic           flash_wait_i,
  // LEDs
  output logic [3:0]     leds_o
);

  // router to flash arbiter and to RAM
  data_bus_if flash_dbus ();
  data_bus_if ram_dbus ();

  data_router u_data_router (
    .IO_CLK        (IO_CLK),
    .IO_RST_N      (IO_RST_N),
    .data_req_i    (data_req_i),
    .data_we_i     (data_we_i),
    .data_be_i     (data_be_i),
    .data_addr_i   (data_addr_i),
    .data_wdata_i  (data_wdata_i),
    .data_gnt_o    (data_gnt_o),
    .data_rvalid_o (data_rvalid_o),
    .data_rdata_o  (data_rdata_o),
    .flash_dbus    (flash_dbus.requester),
    .ram_dbus      (ram_dbus.requester)
  );

  flash_arbiter u_flash_arbiter (
    .IO_CLK         (IO_CLK),
    .IO_RST_N       (IO_RST_N),
    .instr_req_i    (instr_req_i),
    .instr_addr_i   (instr_addr_i),
    .instr_gnt_o    (instr_gnt_o),
    .instr_rvalid_o (instr_rvalid_o),
    .instr_rdata_o  (instr_rdata_o),
    .dbus           (flash_dbus.responder),
    .flash_read_o   (flash_read_o),
    .flash_write_o  (flash_write_o),
    .flash_addr_o   (flash_addr_o),
    .flash_be_o     (flash_be_o),
    .flash_wdata_o  (flash_wdata_o),
    .flash_rdata_i  (flash_rdata_i),
    .flash_rvalid_i (flash_rvalid_i),
    .flash_wait_i   (flash_wait_i)
  );

  ram_and_led_port #(
    .ram_words (ram_words)
  ) u_ram_and_led_port (
    .IO_CLK   (IO_CLK),
    .IO_RST_N (IO_RST_N),
    .dbus     (ram_dbus.responder),
    .leds_o   (leds_o)
  );

endmodule

`default_nettype wire

// ==== testbench/tb_flash_model.sv ====
// behavioral external flash
// word-addressed store of 4096 words with random wait and read latency
`default_nettype none

module tb_flash_model (
  input  logic        IO_CLK,
  input  logic        IO_RST_N,
  input  logic        read_i,
  input  logic        write_i,
  input  logic [31:0] addr_i,
  input  logic [3:0]  be_i,
  input  logic [31:0] wdata_i,
  output logic [31:0] rdata_o,
  output logic        rvalid_o,
  output logic        wait_o
);
  timeunit 1ns;
  timeprecision 1ps;

  logic [31:0] mem [4096];
  logic [31:0] lfsr_q = 32'h51cf_8166;
  logic [1:0]  wait_cnt;
  logic [2:0]  lat_cnt;
  logic        pending;
  logic [11:0] rd_idx;

  // galois LFSR stepped once per bit taken
  function automatic logic [31:0] take_bits(input int n);
    logic [31:0] r;
    r = '0;
    for (int i = 0; i < n; i++) begin
      lfsr_q = lfsr_q[0] ? ((lfsr_q >> 1) ^ 32'h8020_0003) : (lfsr_q >> 1);
      r = {r[30:0], lfsr_q[0]};
    end
    return r;
  endfunction

  // fill pattern over the whole word address
  initial begin
    for (int i = 0; i < 4096; i++) begin
      mem[i] = (i * 32'h9e37_79b9) ^ 32'h0f1e_2d3c;
    end
  end

  assign wait_o = (wait_cnt != 2'd0);

  always @(posedge IO_CLK or negedge IO_RST_N) begin
    if (!IO_RST_N) begin
      wait_cnt <= 2'd0;
      lat_cnt  <= 3'd0;
      pending  <= 1'b0;
      rvalid_o <= 1'b0;
      rdata_o  <= '0;
    end else begin
      rvalid_o <= 1'b0;
      if ((read_i || write_i) && !pending) begin
        if (wait_cnt != 2'd0) begin
          wait_cnt <= wait_cnt - 2'd1;
        end else begin
          // accepted here so the next access draws fresh wait states
          wait_cnt <= 2'(take_bits(2));
          if (write_i) begin
            for (int b = 0; b < 4; b++) begin
              if (be_i[b]) begin
                mem[addr_i[11:0]][b*8 +: 8] <= wdata_i[b*8 +: 8];
              end
            end
          end else begin
            pending <= 1'b1;
            rd_idx  <= addr_i[11:0];
            // latency of 1 to 4 cycles
            lat_cnt <= 3'd1 + 3'(take_bits(2));
          end
        end
      end
      if (pending) begin
        if (lat_cnt == 3'd1) begin
          rvalid_o <= 1'b1;
          rdata_o  <= mem[rd_idx];
          pending  <= 1'b0;
        end else begin
          lat_cnt <= lat_cnt - 3'd1;
        end
      end
    end
  end

endmodule

`default_nettype wire

// ==== testbench/soc_bus_checker.sv ====
// protocol checker bound into the bus fabric
// grant/rvalid pairing per core port and flash strobe rules
`default_nettype none

module soc_bus_checker (
  input logic        IO_CLK,
  input logic        IO_RST_N,
  input logic        instr_gnt_i,
  input logic        instr_rvalid_i,
  input logic        data_gnt_i,
  input logic        data_rvalid_i,
  input logic        flash_read_i,
  input logic        flash_write_i,
  input logic        flash_wait_i,
  input logic [31:0] flash_addr_i,
  input logic [3:0]  flash_be_i,
  input logic [31:0] flash_wdata_i
);
  timeunit 1ns;
  timeprecision 1ps;

  // response still owed on a port
  logic instr_open_q;
  logic data_open_q;

  always_ff @(posedge IO_CLK or negedge IO_RST_N) begin
    if (!IO_RST_N) begin
      instr_open_q <= 1'b0;
      data_open_q  <= 1'b0;
    end else begin
      if (instr_gnt_i) begin
        instr_open_q <= 1'b1;
      end else if (instr_rvalid_i) begin
        instr_open_q <= 1'b0;
      end
      if (data_gnt_i) begin
        data_open_q <= 1'b1;
      end else if (data_rvalid_i) begin
        data_open_q <= 1'b0;
      end
    end
  end

  // next grant only once the previous response came
  instr_gnt_paired: assert property (@(posedge IO_CLK) disable iff (!IO_RST_N)
    instr_gnt_i |-> (!instr_open_q || instr_rvalid_i))
    else $error("instruction grant while a response is still owed");
  // no rvalid without a grant before it
  instr_rvalid_paired: assert property (@(posedge IO_CLK) disable iff (!IO_RST_N)
    instr_rvalid_i |-> instr_open_q)
    else $error("instruction rvalid without an open grant");
  data_gnt_paired: assert property (@(posedge IO_CLK) disable iff (!IO_RST_N)
    data_gnt_i |-> (!data_open_q || data_rvalid_i))
    else $error("data grant while a response is still owed");
  data_rvalid_paired: assert property (@(posedge IO_CLK) disable iff (!IO_RST_N)
    data_rvalid_i |-> data_open_q)
    else $error("data rvalid without an open grant");

  // strobe and payload frozen under wait
  strobe_held: assert property (@(posedge IO_CLK) disable iff (!IO_RST_N)
    (flash_read_i || flash_write_i) && flash_wait_i |=>
      $stable(flash_read_i) && $stable(flash_write_i) && $stable(flash_addr_i) &&
      $stable(flash_be_i) && $stable(flash_wdata_i))
    else $error("flash strobe or payload changed while wait was high");
  one_strobe: assert property (@(posedge IO_CLK) disable iff (!IO_RST_N)
    !(flash_read_i && flash_write_i))
    else $error("flash read and write strobes high together");

endmodule

bind soc_bus_fabric soc_bus_checker u_soc_bus_checker (
  .IO_CLK         (IO_CLK),
  .IO_RST_N       (IO_RST_N),
  .instr_gnt_i    (instr_gnt_o),
  .instr_rvalid_i (instr_rvalid_o),
  .data_gnt_i     (data_gnt_o),
  .data_rvalid_i  (data_rvalid_o),
  .flash_read_i   (flash_read_o),
  .flash_write_i  (flash_write_o),
  .flash_wait_i   (flash_wait_i),
  .flash_addr_i   (flash_addr_o),
  .flash_be_i     (flash_be_o),
  .flash_wdata_i  (flash_wdata_o)
);

`default_nettype wire

// ==== testbench/tb_soc_bus_fabric.sv ====
// testbench of the bus fabric
// core-side directed tests against RAM, LED register and a flash model
`default_nettype none

module tb_soc_bus_fabric;
  timeunit 1ns;
  timeprecision 1ps;
  import mem_map_pkg::*;
  import bus_pkg::*;

  localparam int clk_period   = 20;
  localparam int reset_cycles = 10;
  localparam int ram_checks   = 6;
  localparam int fetch_count  = 3;
  // three per RAM word, two per flash word, fetches, priority pair, LED
  localparam int n_accesses     = 3 * ram_checks + 4 + fetch_count + 2 + 3;
  localparam int timeout_cycles = reset_cycles + 200 * n_accesses;

  logic  IO_CLK;
  logic  IO_RST_N;
  logic  instr_req_i;
  addr_t instr_addr_i;
  logic  instr_gnt_o;
  logic  instr_rvalid_o;
  word_t instr_rdata_o;
  logic  data_req_i;
  logic  data_we_i;
  be_t   data_be_i;
  addr_t data_addr_i;
  word_t data_wdata_i;
  logic  data_gnt_o;
  logic  data_rvalid_o;
  word_t data_rdata_o;
  logic  flash_read_o;
  logic  flash_write_o;
  addr_t flash_addr_o;
  be_t   flash_be_o;
  word_t flash_wdata_o;
  word_t flash_rdata_i;
  logic  flash_rvalid_i;
  logic  flash_wait_i;
  logic [3:0] leds_o;

  int n_checks = 0;
  int n_errors = 0;
  logic [31:0] lfsr_q = 32'h51cf_8166;

  soc_bus_fabric #(
    .ram_words (2048)
  ) dut_i (
    .IO_CLK         (IO_CLK),
    .IO_RST_N       (IO_RST_N),
    .instr_req_i    (instr_req_i),
    .instr_addr_i   (instr_addr_i),
    .instr_gnt_o    (instr_gnt_o),
    .instr_rvalid_o (instr_rvalid_o),
    .instr_rdata_o  (instr_rdata_o),
    .data_req_i     (data_req_i),
    .data_we_i      (data_we_i),
    .data_be_i      (data_be_i),
    .data_addr_i    (data_addr_i),
    .data_wdata_i   (data_wdata_i),
    .data_gnt_o     (data_gnt_o),
    .data_rvalid_o  (data_rvalid_o),
    .data_rdata_o   (data_rdata_o),
    .flash_read_o   (flash_read_o),
    .flash_write_o  (flash_write_o),
    .flash_addr_o   (flash_addr_o),
    .flash_be_o     (flash_be_o),
    .flash_wdata_o  (flash_wdata_o),
    .flash_rdata_i  (flash_rdata_i),
    .flash_rvalid_i (flash_rvalid_i),
    .flash_wait_i   (flash_wait_i),
    .leds_o         (leds_o)
  );

  tb_flash_model u_flash (
    .IO_CLK   (IO_CLK),
    .IO_RST_N (IO_RST_N),
    .read_i   (flash_read_o),
    .write_i  (flash_write_o),
    .addr_i   (flash_addr_o),
    .be_i     (flash_be_o),
    .wdata_i  (flash_wdata_o),
    .rdata_o  (flash_rdata_i),
    .rvalid_o (flash_rvalid_i),
    .wait_o   (flash_wait_i)
  );

  initial begin
    IO_CLK = 1'b0;
    forever #(clk_period / 2) IO_CLK = ~IO_CLK;
  end

  // galois LFSR stepped once per bit taken
  function automatic logic [31:0] take_bits(input int n);
    logic [31:0] r;
    r = '0;
    for (int i = 0; i < n; i++) begin
      lfsr_q = lfsr_q[0] ? ((lfsr_q >> 1) ^ 32'h8020_0003) : (lfsr_q >> 1);
      r = {r[30:0], lfsr_q[0]};
    end
    return r;
  endfunction

  // flash holds words in reversed byte order
  function automatic word_t reverse_bytes(input word_t w);
    return {w[7:0], w[15:8], w[23:16], w[31:24]};
  endfunction

  // enabled bytes of the new word over the old one
  function automatic word_t merge_bytes(input word_t old_w, input word_t new_w, input be_t be);
    word_t m;
    m = old_w;
    for (int i = 0; i < 4; i++) begin
      if (be[i]) begin
        m[i*8 +: 8] = new_w[i*8 +: 8];
      end
    end
    return m;
  endfunction

  task automatic compare_word(input word_t got, input word_t exp, input string what);
    n_checks++;
    assert (got === exp) else begin
      n_errors++;
      $display("CHECK FAILED at %0d ns: %s, got %08h, expected %08h", $time, what, got, exp);
    end
  endtask

  task automatic expect_true(input logic cond, input string what);
    n_checks++;
    assert (cond === 1'b1) else begin
      n_errors++;
      $display("CHECK FAILED at %0d ns: %s", $time, what);
    end
  endtask

  // one core data access with cycles counted from the request edge
  task automatic data_access(input logic we, input addr_t addr, input be_t be,
                             input word_t wdata, output word_t rdata,
                             output int gnt_cycles, output int rsp_cycles);
    @(posedge IO_CLK);
    data_req_i   <= 1'b1;
    data_we_i    <= we;
    data_addr_i  <= addr;
    data_be_i    <= be;
    data_wdata_i <= wdata;
    gnt_cycles = 0;
    @(negedge IO_CLK);
    while (!data_gnt_o) begin
      gnt_cycles++;
      @(negedge IO_CLK);
    end
    @(posedge IO_CLK);
    data_req_i <= 1'b0;
    rsp_cycles = 0;
    do begin
      @(negedge IO_CLK);
      rsp_cycles++;
    end while (!data_rvalid_o);
    rdata = data_rdata_o;
  endtask

  task automatic fetch_instr(input addr_t addr, output word_t rdata, output int gnt_cycles);
    @(posedge IO_CLK);
    instr_req_i  <= 1'b1;
    instr_addr_i <= addr;
    gnt_cycles = 0;
    @(negedge IO_CLK);
    while (!instr_gnt_o) begin
      gnt_cycles++;
      @(negedge IO_CLK);
    end
    @(posedge IO_CLK);
    instr_req_i <= 1'b0;
    do begin
      @(negedge IO_CLK);
    end while (!instr_rvalid_o);
    rdata = instr_rdata_o;
  endtask

  task automatic reset_state();
    @(negedge IO_CLK);
    expect_true(!instr_gnt_o && !instr_rvalid_o, "instruction grant and rvalid low after reset");
    expect_true(!data_gnt_o && !data_rvalid_o, "data grant and rvalid low after reset");
    expect_true(!flash_read_o && !flash_write_o, "flash strobes low after reset");
    compare_word(word_t'(leds_o), '0, "LEDs after reset");
  endtask

  task automatic ram_readback();
    addr_t a;
    word_t full_w;
    word_t part_w;
    word_t got;
    be_t   be;
    int    gc;
    int    rc;
    for (int n = 0; n < ram_checks; n++) begin
      a      = RAM_OFFSET + (take_bits(11) << 2);
      full_w = take_bits(32);
      part_w = take_bits(32);
      be     = be_t'(take_bits(4));
      data_access(1'b1, a, 4'hf, full_w, got, gc, rc);
      expect_true(gc == 0 && rc == 1, "RAM write granted at once, rvalid one cycle later");
      data_access(1'b1, a, be, part_w, got, gc, rc);
      data_access(1'b0, a, 4'hf, '0, got, gc, rc);
      expect_true(gc == 0 && rc == 1, "RAM read granted at once, rvalid one cycle later");
      compare_word(got, merge_bytes(full_w, part_w, be), "RAM read-back");
    end
  endtask

  task automatic flash_roundtrip();
    addr_t a;
    word_t w;
    word_t got;
    int    gc;
    int    rc;
    for (int n = 0; n < 2; n++) begin
      a = take_bits(12) << 2;
      w = take_bits(32);
      data_access(1'b1, a, 4'hf, w, got, gc, rc);
      expect_true(gc == 1, "flash data grant one cycle after the request");
      compare_word(u_flash.mem[a[13:2]], reverse_bytes(w), "flash storage byte-reversed");
      data_access(1'b0, a, 4'hf, '0, got, gc, rc);
      compare_word(got, w, "flash data read-back");
    end
  endtask

  task automatic fetch_from_flash();
    addr_t a;
    word_t exp;
    word_t got;
    int    gc;
    for (int n = 0; n < fetch_count; n++) begin
      a   = take_bits(12) << 2;
      exp = reverse_bytes(u_flash.mem[a[13:2]]);
      fetch_instr(a, got, gc);
      expect_true(gc == 1, "instruction grant one cycle after the request");
      compare_word(got, exp, "instruction fetch");
    end
  endtask

  // both ports ask in the same cycle
  task automatic instr_priority();
    addr_t ia;
    addr_t da;
    word_t iexp;
    word_t dexp;
    word_t igot;
    word_t dgot;
    logic  ig;
    logic  dg;
    logic  instr_done;
    logic  data_done;
    ia         = take_bits(12) << 2;
    da         = take_bits(12) << 2;
    iexp       = reverse_bytes(u_flash.mem[ia[13:2]]);
    dexp       = reverse_bytes(u_flash.mem[da[13:2]]);
    instr_done = 1'b0;
    data_done  = 1'b0;
    @(posedge IO_CLK);
    instr_req_i  <= 1'b1;
    instr_addr_i <= ia;
    data_req_i   <= 1'b1;
    data_we_i    <= 1'b0;
    data_addr_i  <= da;
    data_be_i    <= 4'hf;
    while (!(instr_done && data_done)) begin
      @(negedge IO_CLK);
      ig = instr_gnt_o;
      dg = data_gnt_o;
      if (dg) begin
        expect_true(instr_done, "data grant only after the instruction rvalid");
      end
      if (instr_rvalid_o) begin
        instr_done = 1'b1;
        igot       = instr_rdata_o;
      end
      if (data_rvalid_o) begin
        data_done = 1'b1;
        dgot      = data_rdata_o;
      end
      @(posedge IO_CLK);
      if (ig) begin
        instr_req_i <= 1'b0;
      end
      if (dg) begin
        data_req_i <= 1'b0;
      end
    end
    compare_word(igot, iexp, "instruction word under contention");
    compare_word(dgot, dexp, "data word under contention");
  endtask

  task automatic led_register();
    word_t w1;
    word_t w2;
    word_t got;
    int    gc;
    int    rc;
    w1 = take_bits(32);
    w2 = take_bits(32);
    data_access(1'b1, LED_ADDR, 4'hf, w1, got, gc, rc);
    // byte 3 is the highest enabled
    compare_word(word_t'(leds_o), word_t'(w1[27:24]), "LEDs after full-word write");
    data_access(1'b1, LED_ADDR, 4'b0110, w2, got, gc, rc);
    compare_word(word_t'(leds_o), word_t'(w2[19:16]), "LEDs after write of bytes 1 and 2");
    data_access(1'b0, LED_ADDR, 4'hf, '0, got, gc, rc);
    compare_word(got, merge_bytes(w1, w2, 4'b0110), "LED word read back from RAM");
  endtask

  initial begin
    IO_RST_N     = 1'b0;
    instr_req_i  = 1'b0;
    instr_addr_i = '0;
    data_req_i   = 1'b0;
    data_we_i    = 1'b0;
    data_be_i    = '0;
    data_addr_i  = '0;
    data_wdata_i = '0;
    repeat (reset_cycles) @(posedge IO_CLK);
    IO_RST_N <= 1'b1;
    reset_state();
    ram_readback();
    flash_roundtrip();
    fetch_from_flash();
    instr_priority();
    led_register();
    repeat (2) @(posedge IO_CLK);
    $display("%0d checks, %0d errors", n_checks, n_errors);
    if (n_errors == 0) begin
      $display("Test passed");
    end else begin
      $display("Test failed");
    end
    $finish;
  end

  // watchdog sized by the number of accesses
  initial begin
    #(timeout_cycles * clk_period);
    $display("timeout: the DUT did not finish within %0d cycles", timeout_cycles);
    $display("Test failed");
    $finish;
  end

endmodule

`default_nettype wire

// ==== vlog.f ====
src/mem_map_pkg.sv
src/bus_pkg.sv
src/data_bus_if.sv
src/flash_arbiter.sv
src/ram_and_led_port.sv
src/data_router.sv
src/soc_bus_fabric.sv
testbench/tb_flash_model.sv
testbench/soc_bus_checker.sv
testbench/tb_soc_bus_fabric.sv

// ==== Makefile ====
# Verilator build and run of the bus fabric testbench

SIM = obj_dir/Vtb_soc_bus_fabric
SOURCES = vlog.f $(wildcard src/*.sv) $(wildcard testbench/*.sv)

.PHONY: all run clean

all: run

# rebuilt only when a source or the file list changes
$(SIM): $(SOURCES)
	verilator --binary --timing --assert --timescale 1ns/1ps -j 0 \
		--top-module tb_soc_bus_fabric -f vlog.f

# output goes to the terminal, status comes from the pass line
run: $(SIM)
	./$(SIM) | awk '{ print } /^Test passed$$/ { ok = 1 } END { exit !ok }'

clean:
	rm -rf obj_dir
